// ==== hw/soc_pkg.sv ====
package soc_pkg;

    // Bus widths
    localparam int unsigned addr_w = 32;
    localparam int unsigned data_w = 32;
    localparam int unsigned strb_w = data_w / 8;   // One strobe per byte lane
    localparam int unsigned resp_w = 2;

    localparam logic [resp_w-1:0] resp_okay   = 2'b00;
    localparam logic [resp_w-1:0] resp_decerr = 2'b11;   // No device at this address

    // Address map, match when (addr & mask) == base
    localparam logic [addr_w-1:0] sram_base  = 32'h8000_0000;
    localparam logic [addr_w-1:0] sram_mask  = 32'hf000_0000;
    localparam logic [addr_w-1:0] uart_base  = 32'ha000_03f8;
    localparam logic [addr_w-1:0] uart_mask  = 32'hffff_ffff;   // Exact match
    localparam logic [addr_w-1:0] clint_base = 32'ha000_0048;
    localparam logic [addr_w-1:0] clint_mask = 32'hffff_fff8;   // Two words

    localparam int unsigned sram_words = 1024;
    localparam int unsigned sram_idx_w = $clog2(sram_words);

    // Device slots on the crossbar
    localparam int unsigned n_dev     = 3;
    localparam int unsigned dev_sram  = 0;
    localparam int unsigned dev_uart  = 1;
    localparam int unsigned dev_clint = 2;

    localparam int unsigned mtime_lo_off = 0;   // Word offsets in CLINT window
    localparam int unsigned mtime_hi_off = 1;

endpackage

// ==== hw/axil_reg_port.sv ====
`timescale 1ns/1ns

module axil_reg_port #(
    parameter int unsigned idx_w = 1            // Word index bits handed to the device
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [soc_pkg::addr_w-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [soc_pkg::data_w-1:0]  wdata,
    input  logic [soc_pkg::strb_w-1:0]  wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [soc_pkg::resp_w-1:0]  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [soc_pkg::addr_w-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [soc_pkg::data_w-1:0]  rdata,
    output logic [soc_pkg::resp_w-1:0]  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    output logic                        acc_en,
    output logic                        acc_we,
    output logic [idx_w-1:0]            acc_idx,
    output logic [soc_pkg::data_w-1:0]  acc_wdata,
    output logic [soc_pkg::strb_w-1:0]  acc_wstrb,
    input  logic [soc_pkg::data_w-1:0]  acc_rdata
);
    import soc_pkg::*;

    logic              aw_got;     // Write address held
    logic              w_got;      // Write data held
    logic              ar_got;     // Read address held
    logic [addr_w-1:0] addr_q;     // Shared, one transaction at a time
    logic [data_w-1:0] wdata_q;
    logic [strb_w-1:0] wstrb_q;
    logic [data_w-1:0] rdata_q;    // Frozen while rvalid waits

    assign awready = !aw_got && !bvalid;
    assign wready  = !w_got && !bvalid;
    assign arready = !ar_got && !rvalid;

    // Single-cycle access once a request is complete
    assign acc_we    = aw_got && w_got;
    assign acc_en    = acc_we || ar_got;
    assign acc_idx   = addr_q[idx_w+1:2];   // Byte address to word index
    assign acc_wdata = wdata_q;
    assign acc_wstrb = wstrb_q;

    assign bresp = resp_okay;
    assign rresp = resp_okay;
    assign rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            ar_got <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (awvalid && awready) aw_got <= 1'b1;
            if (wvalid && wready) w_got <= 1'b1;
            if (arvalid && arready) ar_got <= 1'b1;
            if (acc_we) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
            end else if (ar_got) begin
                ar_got <= 1'b0;
                rvalid <= 1'b1;
            end
            if (bvalid && bready) bvalid <= 1'b0;
            if (rvalid && rready) rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) addr_q <= awaddr;
        else if (arvalid && arready) addr_q <= araddr;
        if (wvalid && wready) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (acc_en && !acc_we) rdata_q <= acc_rdata;   // Sample device answer
    end

endmodule

// ==== hw/sram_store.sv ====
`timescale 1ns/1ns

module sram_store (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [soc_pkg::addr_w-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [soc_pkg::data_w-1:0]  wdata,
    input  logic [soc_pkg::strb_w-1:0]  wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [soc_pkg::resp_w-1:0]  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [soc_pkg::addr_w-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [soc_pkg::data_w-1:0]  rdata,
    output logic [soc_pkg::resp_w-1:0]  rresp,
    output logic                        rvalid,
    input  logic                        rready
);
    import soc_pkg::*;

    logic                  acc_en;
    logic                  acc_we;
    logic [sram_idx_w-1:0] acc_idx;
    logic [data_w-1:0]     acc_wdata;
    logic [strb_w-1:0]     acc_wstrb;
    logic [data_w-1:0]     acc_rdata;
    logic [data_w-1:0]     mem [sram_words];

    axil_reg_port #(.idx_w(sram_idx_w)) axil_reg_port_inst (.*);

    assign acc_rdata = mem[acc_idx];   // Async read, port samples it

    always_ff @(posedge clk) begin
        if (acc_en && acc_we) begin
            for (int b = 0; b < strb_w; b++) begin
                if (acc_wstrb[b]) mem[acc_idx][8*b +: 8] <= acc_wdata[8*b +: 8];
            end
        end
    end

endmodule

// ==== hw/clint_timer.sv ====
`timescale 1ns/1ns

module clint_timer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [soc_pkg::addr_w-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [soc_pkg::data_w-1:0]  wdata,
    input  logic [soc_pkg::strb_w-1:0]  wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [soc_pkg::resp_w-1:0]  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [soc_pkg::addr_w-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [soc_pkg::data_w-1:0]  rdata,
    output logic [soc_pkg::resp_w-1:0]  rresp,
    output logic                        rvalid,
    input  logic                        rready
);
    import soc_pkg::*;

    logic                  acc_en;
    logic                  acc_we;
    logic [0:0]            acc_idx;     // Low or high word
    logic [data_w-1:0]     acc_wdata;
    logic [strb_w-1:0]     acc_wstrb;
    logic [data_w-1:0]     acc_rdata;
    logic [2*data_w-1:0]   mtime;
    logic [2*data_w-1:0]   mtime_ld;    // Current value with strobed bytes replaced

    axil_reg_port #(.idx_w(1)) axil_reg_port_inst (.*);

    assign acc_rdata = (acc_idx == mtime_lo_off) ? mtime[data_w-1:0] : mtime[2*data_w-1:data_w];

    always_comb begin
        mtime_ld = mtime;
        for (int b = 0; b < strb_w; b++) begin
            if (acc_wstrb[b]) begin
                if (acc_idx == mtime_hi_off) mtime_ld[data_w+8*b +: 8] = acc_wdata[8*b +: 8];
                else mtime_ld[8*b +: 8] = acc_wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) mtime <= '0;
        else if (acc_en && acc_we) mtime <= mtime_ld;   // Load skips one tick
        else mtime <= mtime + 1'b1;
    end

endmodule

// ==== hw/uart_tx_reg.sv ====
`timescale 1ns/1ns

module uart_tx_reg (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [soc_pkg::addr_w-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [soc_pkg::data_w-1:0]  wdata,
    input  logic [soc_pkg::strb_w-1:0]  wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [soc_pkg::resp_w-1:0]  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [soc_pkg::addr_w-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [soc_pkg::data_w-1:0]  rdata,
    output logic [soc_pkg::resp_w-1:0]  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [7:0]                  tx_data,
    output logic                        tx_valid    // One cycle per byte
);
    import soc_pkg::*;

    logic              acc_en;
    logic              acc_we;
    logic [data_w-1:0] acc_wdata;
    logic [strb_w-1:0] acc_wstrb;
    logic [data_w-1:0] acc_rdata;
    logic              tx_load;    // Write touching byte lane 0

    // Single register, word index not needed
    axil_reg_port #(.idx_w(1)) axil_reg_port_inst (.*, .acc_idx());

    assign tx_load   = acc_en && acc_we && acc_wstrb[0];
    assign acc_rdata = {{(data_w-8){1'b0}}, tx_data};

    always_ff @(posedge clk) begin
        if (rst) tx_valid <= 1'b0;
        else tx_valid <= tx_load;
    end

    always_ff @(posedge clk) begin
        if (tx_load) tx_data <= acc_wdata[7:0];
    end

endmodule

// ==== hw/axil_xbar.sv ====
`timescale 1ns/1ns

module axil_xbar (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [soc_pkg::addr_w-1:0]                awaddr,
    input  logic                                      awvalid,
    output logic                                      awready,
    input  logic [soc_pkg::data_w-1:0]                wdata,
    input  logic [soc_pkg::strb_w-1:0]                wstrb,
    input  logic                                      wvalid,
    output logic                                      wready,
    output logic [soc_pkg::resp_w-1:0]                bresp,
    output logic                                      bvalid,
    input  logic                                      bready,
    input  logic [soc_pkg::addr_w-1:0]                araddr,
    input  logic                                      arvalid,
    output logic                                      arready,
    output logic [soc_pkg::data_w-1:0]                rdata,
    output logic [soc_pkg::resp_w-1:0]                rresp,
    output logic                                      rvalid,
    input  logic                                      rready,
    output logic [soc_pkg::addr_w-1:0]                dev_awaddr,
    output logic [soc_pkg::n_dev-1:0]                 dev_awvalid,
    input  logic [soc_pkg::n_dev-1:0]                 dev_awready,
    output logic [soc_pkg::data_w-1:0]                dev_wdata,
    output logic [soc_pkg::strb_w-1:0]                dev_wstrb,
    output logic [soc_pkg::n_dev-1:0]                 dev_wvalid,
    input  logic [soc_pkg::n_dev-1:0]                 dev_wready,
    input  logic [soc_pkg::n_dev*soc_pkg::resp_w-1:0] dev_bresp,
    input  logic [soc_pkg::n_dev-1:0]                 dev_bvalid,
    output logic [soc_pkg::n_dev-1:0]                 dev_bready,
    output logic [soc_pkg::addr_w-1:0]                dev_araddr,
    output logic [soc_pkg::n_dev-1:0]                 dev_arvalid,
    input  logic [soc_pkg::n_dev-1:0]                 dev_arready,
    input  logic [soc_pkg::n_dev*soc_pkg::data_w-1:0] dev_rdata,
    input  logic [soc_pkg::n_dev*soc_pkg::resp_w-1:0] dev_rresp,
    input  logic [soc_pkg::n_dev-1:0]                 dev_rvalid,
    output logic [soc_pkg::n_dev-1:0]                 dev_rready
);
    import soc_pkg::*;

    logic             wr_open;     // Write transaction in flight
    logic             rd_open;     // Read transaction in flight
    logic [n_dev-1:0] sel_q;       // One-hot target, zero on miss
    logic             hit;
    logic             aw_done;     // Decode-error side, halves taken
    logic             w_done;
    logic             ar_done;

    function automatic logic [n_dev-1:0] decode(input logic [addr_w-1:0] a);
        logic [n_dev-1:0] s;
        s = '0;
        s[dev_sram]  = (a & sram_mask) == sram_base;
        s[dev_uart]  = (a & uart_mask) == uart_base;
        s[dev_clint] = (a & clint_mask) == clint_base;
        return s;
    endfunction

    assign hit = |sel_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_open <= 1'b0;
            rd_open <= 1'b0;
            sel_q   <= '0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            ar_done <= 1'b0;
        end else if (!wr_open && !rd_open) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            ar_done <= 1'b0;
            if (awvalid) begin               // Write wins a tie
                wr_open <= 1'b1;
                sel_q   <= decode(awaddr);
            end else if (arvalid) begin
                rd_open <= 1'b1;
                sel_q   <= decode(araddr);
            end
        end else begin
            if (awvalid && awready) aw_done <= 1'b1;
            if (wvalid && wready) w_done <= 1'b1;
            if (arvalid && arready) ar_done <= 1'b1;
            if (bvalid && bready) wr_open <= 1'b0;
            if (rvalid && rready) rd_open <= 1'b0;
        end
    end

    // Request side, payload broadcast and valid steered to the target
    assign dev_awaddr  = awaddr;
    assign dev_wdata   = wdata;
    assign dev_wstrb   = wstrb;
    assign dev_araddr  = araddr;
    assign dev_awvalid = {n_dev{wr_open && awvalid}} & sel_q;
    assign dev_wvalid  = {n_dev{wr_open && wvalid}} & sel_q;
    assign dev_bready  = {n_dev{wr_open && bready}} & sel_q;
    assign dev_arvalid = {n_dev{rd_open && arvalid}} & sel_q;
    assign dev_rready  = {n_dev{rd_open && rready}} & sel_q;

    // Miss is answered here once its halves are in
    assign awready = wr_open && (hit ? |(sel_q & dev_awready) : !aw_done);
    assign wready  = wr_open && (hit ? |(sel_q & dev_wready) : !w_done);
    assign bvalid  = wr_open && (hit ? |(sel_q & dev_bvalid) : aw_done && w_done);
    assign arready = rd_open && (hit ? |(sel_q & dev_arready) : !ar_done);
    assign rvalid  = rd_open && (hit ? |(sel_q & dev_rvalid) : ar_done);

    always_comb begin
        bresp = resp_decerr;   // Default covers the miss
        rresp = resp_decerr;
        rdata = '0;
        for (int i = 0; i < n_dev; i++) begin
            if (sel_q[i]) begin
                bresp = dev_bresp[i*resp_w +: resp_w];
                rresp = dev_rresp[i*resp_w +: resp_w];
                rdata = dev_rdata[i*data_w +: data_w];
            end
        end
    end

endmodule

// ==== hw/soc_top.sv ====
`timescale 1ns/1ns

module soc_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [soc_pkg::addr_w-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [soc_pkg::data_w-1:0]  wdata,
    input  logic [soc_pkg::strb_w-1:0]  wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [soc_pkg::resp_w-1:0]  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [soc_pkg::addr_w-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [soc_pkg::data_w-1:0]  rdata,
    output logic [soc_pkg::resp_w-1:0]  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [7:0]                  tx_data,   // UART byte out
    output logic                        tx_valid
);
    import soc_pkg::*;

    // Device side, shared payload and per-device handshakes
    logic [addr_w-1:0]        dev_awaddr;
    logic [n_dev-1:0]         dev_awvalid;
    logic [n_dev-1:0]         dev_awready;
    logic [data_w-1:0]        dev_wdata;
    logic [strb_w-1:0]        dev_wstrb;
    logic [n_dev-1:0]         dev_wvalid;
    logic [n_dev-1:0]         dev_wready;
    logic [n_dev*resp_w-1:0]  dev_bresp;
    logic [n_dev-1:0]         dev_bvalid;
    logic [n_dev-1:0]         dev_bready;
    logic [addr_w-1:0]        dev_araddr;
    logic [n_dev-1:0]         dev_arvalid;
    logic [n_dev-1:0]         dev_arready;
    logic [n_dev*data_w-1:0]  dev_rdata;
    logic [n_dev*resp_w-1:0]  dev_rresp;
    logic [n_dev-1:0]         dev_rvalid;
    logic [n_dev-1:0]         dev_rready;

    axil_xbar axil_xbar_inst (.*);   // Names line up one to one

    sram_store sram_store_inst (
        .clk(clk), .rst(rst),
        .awaddr(dev_awaddr), .awvalid(dev_awvalid[dev_sram]), .awready(dev_awready[dev_sram]),
        .wdata(dev_wdata), .wstrb(dev_wstrb),
        .wvalid(dev_wvalid[dev_sram]), .wready(dev_wready[dev_sram]),
        .bresp(dev_bresp[dev_sram*resp_w +: resp_w]),
        .bvalid(dev_bvalid[dev_sram]), .bready(dev_bready[dev_sram]),
        .araddr(dev_araddr), .arvalid(dev_arvalid[dev_sram]), .arready(dev_arready[dev_sram]),
        .rdata(dev_rdata[dev_sram*data_w +: data_w]),
        .rresp(dev_rresp[dev_sram*resp_w +: resp_w]),
        .rvalid(dev_rvalid[dev_sram]), .rready(dev_rready[dev_sram])
    );

    uart_tx_reg uart_tx_reg_inst (
        .clk(clk), .rst(rst), .tx_data(tx_data), .tx_valid(tx_valid),
        .awaddr(dev_awaddr), .awvalid(dev_awvalid[dev_uart]), .awready(dev_awready[dev_uart]),
        .wdata(dev_wdata), .wstrb(dev_wstrb),
        .wvalid(dev_wvalid[dev_uart]), .wready(dev_wready[dev_uart]),
        .bresp(dev_bresp[dev_uart*resp_w +: resp_w]),
        .bvalid(dev_bvalid[dev_uart]), .bready(dev_bready[dev_uart]),
        .araddr(dev_araddr), .arvalid(dev_arvalid[dev_uart]), .arready(dev_arready[dev_uart]),
        .rdata(dev_rdata[dev_uart*data_w +: data_w]),
        .rresp(dev_rresp[dev_uart*resp_w +: resp_w]),
        .rvalid(dev_rvalid[dev_uart]), .rready(dev_rready[dev_uart])
    );

    clint_timer clint_timer_inst (
        .clk(clk), .rst(rst),
        .awaddr(dev_awaddr), .awvalid(dev_awvalid[dev_clint]), .awready(dev_awready[dev_clint]),
        .wdata(dev_wdata), .wstrb(dev_wstrb),
        .wvalid(dev_wvalid[dev_clint]), .wready(dev_wready[dev_clint]),
        .bresp(dev_bresp[dev_clint*resp_w +: resp_w]),
        .bvalid(dev_bvalid[dev_clint]), .bready(dev_bready[dev_clint]),
        .araddr(dev_araddr), .arvalid(dev_arvalid[dev_clint]), .arready(dev_arready[dev_clint]),
        .rdata(dev_rdata[dev_clint*data_w +: data_w]),
        .rresp(dev_rresp[dev_clint*resp_w +: resp_w]),
        .rvalid(dev_rvalid[dev_clint]), .rready(dev_rready[dev_clint])
    );

endmodule

// ==== tests/soc_top_sva.sv ====
`timescale 1ns/1ns

module soc_top_sva (
    input logic                        clk,
    input logic                        rst,
    input logic                        awvalid,
    input logic                        awready,
    input logic                        wvalid,
    input logic                        wready,
    input logic [soc_pkg::resp_w-1:0]  bresp,
    input logic                        bvalid,
    input logic                        bready,
    input logic                        arvalid,
    input logic                        arready,
    input logic [soc_pkg::data_w-1:0]  rdata,
    input logic [soc_pkg::resp_w-1:0]  rresp,
    input logic                        rvalid,
    input logic                        rready,
    input logic                        tx_valid
);

    logic aw_taken;   // Address accepted, response still owed
    logic w_taken;
    logic ar_taken;
    int   fail_count = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_taken <= 1'b0;
            w_taken  <= 1'b0;
            ar_taken <= 1'b0;
        end else begin
            if (awvalid && awready) aw_taken <= 1'b1;
            if (wvalid && wready) w_taken <= 1'b1;
            if (arvalid && arready) ar_taken <= 1'b1;
            if (bvalid && bready) begin   // Write closed
                aw_taken <= 1'b0;
                w_taken  <= 1'b0;
            end
            if (rvalid && rready) ar_taken <= 1'b0;
        end
    end

    b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            fail_count++;
            $error("bvalid dropped or bresp changed before bready");
        end

    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            fail_count++;
            $error("rvalid dropped or read payload changed before rready");
        end

    b_after_req: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> aw_taken && w_taken)
        else begin
            fail_count++;
            $error("write response without accepted address and data");
        end

    r_after_req: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> ar_taken)
        else begin
            fail_count++;
            $error("read response without accepted read address");
        end

    tx_pulse: assert property (@(posedge clk) disable iff (rst)
        tx_valid |=> !tx_valid)
        else begin
            fail_count++;
            $error("tx_valid held longer than one cycle");
        end

endmodule

// ==== tests/soc_top_tb.sv ====
`timescale 1ns/1ns

module soc_top_tb;

    logic        clk;
    logic        rst;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [7:0]  tx_data;
    logic        tx_valid;

    integer seed = 32'hfff7a7b7;
    int     errors = 0;
    int     cycles = 0;
    int     cycle_limit = 400;   // Replaced once the cases are counted
    int     n_cases = 0;
    int     n_wr = 0;            // Responses owed
    int     n_rd = 0;
    int     b_count = 0;         // Responses seen on the bus
    int     r_count = 0;
    int     tx_seen = 0;
    logic [7:0] tx_last;

    string       ops[$];
    logic [31:0] addrs[$];
    logic [31:0] datas[$];
    logic [3:0]  strbs[$];
    logic [31:0] exp_datas[$];
    logic [1:0]  exp_resps[$];

    soc_top soc_top_inst (.*);

    bind soc_top soc_top_sva soc_top_sva_inst (.*);

    always #20 clk = ~clk;   // 40 ns period

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("Summary: %0d cases, %0d errors", n_cases,
                     errors + soc_top_inst.soc_top_sva_inst.fail_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Bus observers sample mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (bvalid && bready) b_count++;
        if (rvalid && rready) r_count++;
        if (tx_valid) begin
            tx_seen++;
            tx_last = tx_data;
        end
    end

    function automatic logic draw_ready();
        return ($random(seed) & 3) != 0;   // Ready three times in four
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic write_op(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
        logic aw_hs;
        logic w_hs;
        logic b_hs;
        b_hs = 1'b0;
        awaddr = addr;
        awvalid = 1'b1;
        wdata = data;
        wstrb = strb;
        wvalid = 1'b1;
        bready = draw_ready();
        while (!b_hs) begin
            @(negedge clk);
            aw_hs = awvalid && awready;
            w_hs = wvalid && wready;
            b_hs = bvalid && bready;
            resp = bresp;
            @(posedge clk);
            #2;
            if (aw_hs) awvalid = 1'b0;   // Each half drops after its own handshake
            if (w_hs) wvalid = 1'b0;
            bready = b_hs ? 1'b0 : draw_ready();
        end
    endtask

    task automatic read_op(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        logic ar_hs;
        logic r_hs;
        r_hs = 1'b0;
        araddr = addr;
        arvalid = 1'b1;
        rready = draw_ready();
        while (!r_hs) begin
            @(negedge clk);
            ar_hs = arvalid && arready;
            r_hs = rvalid && rready;
            data = rdata;
            resp = rresp;
            @(posedge clk);
            #2;
            if (ar_hs) arvalid = 1'b0;
            rready = r_hs ? 1'b0 : draw_ready();
        end
    endtask

    task automatic run_case(input string name, input string op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] strb,
                            input logic [31:0] exp_data, input logic [1:0] exp_resp);
        logic [31:0] got;
        logic [1:0]  resp;
        if (op == "W") begin
            write_op(addr, data, strb, resp);
            n_wr++;
            check_value({name, " bresp"}, exp_resp, resp);
        end else if (op == "R") begin
            read_op(addr, got, resp);
            n_rd++;
            check_value({name, " rdata"}, exp_data, got);
            check_value({name, " rresp"}, exp_resp, resp);
        end else if (op == "T") begin   // Counter read, bounded by the case budget
            read_op(addr, got, resp);
            n_rd++;
            assert (got > exp_data && got < exp_data + 200) else begin
                errors++;
                $display("FAILED %s expected %h..%h actual %h", name, exp_data + 1,
                         exp_data + 199, got);
            end
            check_value({name, " rresp"}, exp_resp, resp);
        end else if (op == "U") begin   // One byte out since the last check
            check_value({name, " tx pulses"}, 1, tx_seen);
            check_value({name, " tx_data"}, exp_data, tx_last);
            tx_seen = 0;
        end else begin
            errors++;
            $display("Unknown operation %s in %s", op, name);
        end
    endtask

    initial begin
        int          fd;
        int          fields;
        string       line;
        string       name;
        string       f_op;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [3:0]  f_strb;
        logic [31:0] f_exp;
        logic [1:0]  f_resp;
        clk = 1'b0;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        fd = $fopen("tests/soc_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open tests/soc_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin   // Skip column notes
                    fields = $sscanf(line, "%s %h %h %h %h %h", f_op, f_addr, f_data,
                                     f_strb, f_exp, f_resp);
                    if (fields == 6) begin
                        ops.push_back(f_op);
                        addrs.push_back(f_addr);
                        datas.push_back(f_data);
                        strbs.push_back(f_strb);
                        exp_datas.push_back(f_exp);
                        exp_resps.push_back(f_resp);
                    end
                end
            end
            $fclose(fd);
        end
        n_cases = ops.size();
        cycle_limit = 200 * (n_cases + 1);   // Extra slot for reset and wrap-up
        if (fd != 0 && n_cases == 0) begin
            errors++;
            $display("No cases found in tests/soc_cases.txt");
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < n_cases; i++) begin
            name = $sformatf("case%0d_%s_%h", i + 1, ops[i], addrs[i]);
            run_case(name, ops[i], addrs[i], datas[i], strbs[i], exp_datas[i], exp_resps[i]);
        end
        @(posedge clk);
        #2;
        check_value("write response count", n_wr, b_count);
        check_value("read response count", n_rd, r_count);
        errors += soc_top_inst.soc_top_sva_inst.fail_count;
        $display("Summary: %0d cases, %0d errors", n_cases, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/soc_pkg.sv
hw/axil_reg_port.sv
hw/sram_store.sv
hw/clint_timer.sv
hw/uart_tx_reg.sv
hw/axil_xbar.sv
hw/soc_top.sv
tests/soc_top_sva.sv
tests/soc_top_tb.sv

// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - files:
      - hw/soc_pkg.sv
      - hw/axil_reg_port.sv
      - hw/sram_store.sv
      - hw/clint_timer.sv
      - hw/uart_tx_reg.sv
      - hw/axil_xbar.sv
      - hw/soc_top.sv
  - target: test
    files:
      - tests/soc_top_sva.sv
      - tests/soc_top_tb.sv

// ==== tests/soc_cases.txt ====
# op addr data strb exp_data exp_resp, all hex
# W write, R read, T mtime read above exp_data, U check last UART byte
W 80000000 deadbeef f 00000000 0
R 80000000 00000000 0 deadbeef 0
W 80000010 11223344 f 00000000 0
W 80000010 aabbccdd 5 00000000 0
R 80000010 00000000 0 11bb33dd 0
W 80000ffc 0badf00d f 00000000 0
W 80000ffc 5a000000 8 00000000 0
R 80000ffc 00000000 0 5aadf00d 0
W a00003f8 000000a5 1 00000000 0
U 00000000 00000000 0 000000a5 0
R a00003f8 00000000 0 000000a5 0
W a000004c 00000012 f 00000000 0
W a0000048 10000000 f 00000000 0
T a0000048 00000000 0 10000000 0
R a000004c 00000000 0 00000012 0
W 40000000 12345678 f 00000000 3
R 40000000 00000000 0 00000000 3
R 80000000 00000000 0 deadbeef 0
R 80000010 00000000 0 11bb33dd 0
R 80000ffc 00000000 0 5aadf00d 0
